//--- dcache_top.f
rtl/dcache_pkg.sv
rtl/dcache_ways.sv
rtl/dcache_wb_buffer.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module dcache_tb -f dcache_top.f -o dcache_sim

out=$(./obj_dir/dcache_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- test/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    localparam int N_ACCESS    = 250;
    localparam int WORST_CYC   = 40;  // drain, stall, read and refill per access
    localparam int TIMEOUT_NS  = (N_ACCESS * WORST_CYC + 200) * 8;

    logic          clk;
    logic          rst;
    logic          valid_i;
    logic          op_i;
    logic          uncache_i;
    logic [31:0]   addr_i;
    logic [3:0]    wstrb_i;
    logic [31:0]   wdata_i;
    wire           ready_o;
    wire           data_ok_o;
    wire  [31:0]   rdata_o;
    wire           rd_req_o;
    wire  [2:0]    rd_type_o;
    wire  [31:0]   rd_addr_o;
    wire           rd_rdy_i;
    wire           ret_valid_i;
    wire  [127:0]  ret_data_i;
    wire           wr_req_o;
    wire  [2:0]    wr_type_o;
    wire  [31:0]   wr_addr_o;
    wire  [15:0]   wr_wstrb_o;
    wire  [127:0]  wr_data_o;
    wire           wr_rdy_i;

    logic [31:0]   ref_mem [4096]; // cpu-visible contents
    logic          dirty_line [1024];
    logic [31:0]   rnd;
    int            last_lat;
    logic          cur_unc;         // request in progress
    logic [31:0]   cur_addr;
    logic          word_wr_pending; // posted uncached store not yet written
    logic [31:0]   word_wr_addr;
    logic [15:0]   word_wr_strb;

    dcache_top dcache_top_i (.*);

    dcache_mem_model mem_i (
        .clk, .rst, .rd_req_i(rd_req_o), .rd_addr_i(rd_addr_o),
        .rd_rdy_o(rd_rdy_i), .ret_valid_o(ret_valid_i), .ret_data_o(ret_data_i),
        .wr_req_i(wr_req_o), .wr_addr_i(wr_addr_o),
        .wr_wstrb_i(wr_wstrb_o), .wr_data_i(wr_data_o), .wr_rdy_o(wr_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // one cpu request with its load data checked against the reference
    task automatic access(input logic op, input logic unc, input logic [31:0] addr,
                          input logic [3:0] strb, input logic [31:0] data);
        int          n;
        logic [31:0] expv;
        @(negedge clk);
        valid_i   = 1'b1;
        op_i      = op;
        uncache_i = unc;
        addr_i    = addr;
        wstrb_i   = strb;
        wdata_i   = data;
        cur_unc   = unc;
        cur_addr  = addr;
        n = 0;
        while (!ready_o) begin
            @(negedge clk);
            n++;
            if (n > 100) abort_run("request was never accepted");
        end
        expv = ref_mem[addr[13:2]];
        @(negedge clk);
        valid_i = 1'b0;
        n = 1;
        @(posedge clk);
        while (!data_ok_o) begin
            @(posedge clk);
            n++;
            if (n > 100) abort_run("no data_ok_o for an accepted request");
        end
        if (!op) begin
            check("rdata_o", rdata_o, expv);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ref_mem[addr[13:2]][8 * b +: 8] = data[8 * b +: 8];
            end
            if (unc) begin
                word_wr_pending = 1'b1;
                word_wr_addr    = {addr[31:2], 2'b00};
                word_wr_strb    = 16'(strb) << (4 * addr[3:2]);
            end else begin
                dirty_line[addr[13:4]] = 1'b1;
            end
        end
        last_lat = n;
    endtask

    always @(posedge clk) begin
        if (!rst && wr_req_o && wr_rdy_i) begin
            if (word_wr_pending) begin
                check("wr_type_o", 32'(wr_type_o), 32'(dcache_pkg::TYPE_WORD));
                check("wr_addr_o", wr_addr_o, word_wr_addr);
                check("wr_wstrb_o", 32'(wr_wstrb_o), 32'(word_wr_strb));
                word_wr_pending = 1'b0;
            end else begin
                // a line written back must hold what the cpu last stored
                check("wr_type_o", 32'(wr_type_o), 32'(dcache_pkg::TYPE_LINE));
                check("wr_wstrb_o", 32'(wr_wstrb_o), 32'hffff);
                for (int i = 0; i < 4; i++) begin
                    check("wr_data_o", wr_data_o[32 * i +: 32],
                          ref_mem[{wr_addr_o[13:4], 2'(i)}]);
                end
                dirty_line[wr_addr_o[13:4]] = 1'b0;
            end
        end
        // reads fetch a line, or one word when uncached
        if (!rst && rd_req_o && rd_rdy_i) begin
            check("rd_type_o", 32'(rd_type_o),
                  cur_unc ? 32'(dcache_pkg::TYPE_WORD) : 32'(dcache_pkg::TYPE_LINE));
            check("rd_addr_o", rd_addr_o,
                  cur_unc ? {cur_addr[31:2], 2'b00} : {cur_addr[31:4], 4'h0});
        end
    end

    task automatic cold_load_reload();
        access(1'b0, 1'b0, 32'h104, 4'h0, 32'h0);
        access(1'b0, 1'b0, 32'h104, 4'h0, 32'h0);
        check("data_ok_o latency", 32'(last_lat), 32'd1);
    endtask

    task automatic strobed_stores();
        access(1'b1, 1'b0, 32'h100, 4'b0001, 32'h0000_00a1);
        access(1'b1, 1'b0, 32'h104, 4'b0010, 32'h0000_b200);
        access(1'b1, 1'b0, 32'h108, 4'b1100, 32'hc3c4_0000);
        access(1'b1, 1'b0, 32'h10c, 4'b1111, 32'hd1d2_d3d4);
        access(1'b1, 1'b0, 32'h100, 4'b1000, 32'he500_0000);
        access(1'b1, 1'b0, 32'h104, 4'b0011, 32'h0000_f6f7);
        for (int w = 0; w < 4; w++) access(1'b0, 1'b0, 32'h100 + 4 * w, 4'h0, 32'h0);
    endtask

    task automatic store_miss();
        access(1'b1, 1'b0, 32'h248, 4'b0110, 32'h0077_8800);
        for (int w = 0; w < 4; w++) access(1'b0, 1'b0, 32'h240 + 4 * w, 4'h0, 32'h0);
    endtask

    task automatic same_index_evict();
        for (int k = 0; k < 4; k++) access(1'b1, 1'b0, 32'h304 + k * 32'h1000, 4'hf, 32'h5000 + k);
        for (int k = 0; k < 4; k++) access(1'b0, 1'b0, 32'h304 + k * 32'h1000, 4'h0, 32'h0);
    endtask

    task automatic uncached_access();
        access(1'b1, 1'b1, 32'h808, 4'b1111, 32'hcafe_f00d);
        access(1'b0, 1'b1, 32'h808, 4'h0, 32'h0);
        access(1'b0, 1'b0, 32'h90c, 4'h0, 32'h0);
    endtask

    task automatic random_mix();
        logic [31:0] addr;
        logic [3:0]  strb;
        for (int n = 0; n < 200; n++) begin
            rnd  = lcg_next(rnd);
            addr = {18'b0, rnd[29:28], 5'b0, rnd[26:24], rnd[23:22], 2'b00};
            strb = (rnd[20:17] == 4'h0) ? 4'hf : rnd[20:17];
            if (rnd[16]) begin
                access(1'b1, 1'b0, addr, strb, lcg_next(rnd));
            end else begin
                access(1'b0, 1'b0, addr, 4'h0, 32'h0);
            end
        end
    endtask

    initial begin
        rst             = 1'b1;
        valid_i         = 1'b0;
        op_i            = 1'b0;
        uncache_i       = 1'b0;
        addr_i          = '0;
        wstrb_i         = '0;
        wdata_i         = '0;
        rnd             = 32'd95808;
        cur_unc         = 1'b0;
        cur_addr        = '0;
        word_wr_pending = 1'b0;
        word_wr_addr    = '0;
        word_wr_strb    = '0;
        for (int k = 0; k < 4096; k++) ref_mem[k] = k * 32'h9e3779b1 + 32'h1234_5678;
        for (int k = 0; k < 1024; k++) dirty_line[k] = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cold_load_reload();
        strobed_stores();
        store_miss();
        same_index_evict();
        uncached_access();
        random_mix();
        // drain the write buffer
        while (wr_req_o) @(negedge clk);
        for (int k = 0; k < 4096; k++) begin
            // lines still dirty in the cache are skipped
            if (!dirty_line[k >> 2]) check("mem_i.mem", mem_i.mem[k], ref_mem[k]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dcache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model (
    input  wire           clk,
    input  wire           rst,
    input  wire           rd_req_i,
    input  wire  [31:0]   rd_addr_i,
    output logic          rd_rdy_o,
    output logic          ret_valid_o,
    output logic [127:0]  ret_data_o,
    input  wire           wr_req_i,
    input  wire  [31:0]   wr_addr_i,
    input  wire  [15:0]   wr_wstrb_i,
    input  wire  [127:0]  wr_data_i,
    output logic          wr_rdy_o
);

    logic [31:0] mem [4096];
    logic [31:0] seed;
    logic [1:0]  rd_stall;
    logic [1:0]  wr_stall;
    logic        busy;
    logic [1:0]  ret_cnt;
    logic [9:0]  line;

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int k = 0; k < 4096; k++) begin
            mem[k] = k * 32'h9e3779b1 + 32'h1234_5678; // pattern over the whole address
        end
        seed        = 32'd95808;
        rd_rdy_o    = 1'b0;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_rdy_o    = 1'b0;
    end

    always @(negedge clk) begin
        rd_rdy_o    <= 1'b0;
        ret_valid_o <= 1'b0;
        wr_rdy_o    <= 1'b0;
        if (rst) begin
            busy     <= 1'b0;
            rd_stall <= 2'd0;
            wr_stall <= 2'd0;
        end else begin
            if (busy) begin
                if (ret_cnt == 2'd0) begin
                    ret_valid_o <= 1'b1; // whole aligned line, word sits in its lane
                    ret_data_o  <= {mem[{line, 2'd3}], mem[{line, 2'd2}],
                                    mem[{line, 2'd1}], mem[{line, 2'd0}]};
                    busy        <= 1'b0;
                end else begin
                    ret_cnt <= ret_cnt - 2'd1;
                end
            end else if (rd_req_i && !rd_rdy_o) begin
                if (rd_stall == 2'd0) begin
                    rd_rdy_o <= 1'b1;
                    line     <= rd_addr_i[13:4];
                    busy     <= 1'b1;
                    ret_cnt  <= 2'd2;
                    seed = step_lcg(seed);
                    rd_stall <= seed[17:16] % 3;
                end else begin
                    rd_stall <= rd_stall - 2'd1;
                end
            end
            if (wr_req_i && !wr_rdy_o) begin
                if (wr_stall == 2'd0) begin
                    wr_rdy_o <= 1'b1;
                    for (int i = 0; i < 16; i++) begin
                        if (wr_wstrb_i[i]) begin
                            mem[{wr_addr_i[13:4], 2'(i >> 2)}][8 * (i % 4) +: 8] =
                                wr_data_i[8 * i +: 8];
                        end
                    end
                    seed = step_lcg(seed);
                    wr_stall <= seed[19:18] % 3;
                end else begin
                    wr_stall <= wr_stall - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                valid_i,
    input  wire                                op_i,
    input  wire                                uncache_i,
    input  wire  [31:0]                        addr_i,
    input  wire  [3:0]                         wstrb_i,
    input  wire  [dcache_pkg::WORD_W-1:0]      wdata_i,
    output logic                               ready_o,
    output logic                               data_ok_o,
    output logic [dcache_pkg::WORD_W-1:0]      rdata_o,
    output logic                               rd_req_o,
    output logic [2:0]                         rd_type_o,
    output logic [31:0]                        rd_addr_o,
    input  wire                                rd_rdy_i,
    input  wire                                ret_valid_i,
    input  wire  [dcache_pkg::LINE_W-1:0]      ret_data_i,
    output logic                               wr_req_o,
    output logic [2:0]                         wr_type_o,
    output logic [31:0]                        wr_addr_o,
    output logic [dcache_pkg::LINE_BYTES-1:0]  wr_wstrb_o,
    output logic [dcache_pkg::LINE_W-1:0]      wr_data_o,
    input  wire                                wr_rdy_i
);

    // array read and compare
    logic                              rd_en;
    logic [dcache_pkg::INDEX_W-1:0]    rd_index;
    logic [dcache_pkg::TAG_W-1:0]      cmp_tag;
    logic                              hit;
    logic                              hit_way;
    dcache_pkg::line_t                 hit_line;
    logic                              victim_way;
    logic                              victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]      victim_tag;
    dcache_pkg::line_t                 victim_line;
    // array write
    logic                              arr_wr_en;
    logic                              arr_wr_way;
    logic [dcache_pkg::INDEX_W-1:0]    arr_wr_index;
    logic [dcache_pkg::TAG_W-1:0]      arr_wr_tag;
    logic                              arr_wr_dirty;
    dcache_pkg::line_t                 arr_wr_line;
    logic [dcache_pkg::LINE_BYTES-1:0] arr_wr_byte_en;
    // write buffer push
    logic                              push;
    logic                              push_line;
    logic [31:0]                       push_addr;
    dcache_pkg::line_t                 push_data;
    logic [dcache_pkg::LINE_BYTES-1:0] push_strb;
    logic                              wb_empty;

    dcache_ctrl ctrl_i (
        .clk, .rst, .valid_i, .op_i, .uncache_i, .addr_i, .wstrb_i, .wdata_i,
        .ready_o, .data_ok_o, .rdata_o,
        .rd_en_o(rd_en), .rd_index_o(rd_index), .cmp_tag_o(cmp_tag),
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .victim_line_i(victim_line),
        .wr_en_o(arr_wr_en), .wr_way_o(arr_wr_way), .wr_index_o(arr_wr_index),
        .wr_tag_o(arr_wr_tag), .wr_dirty_o(arr_wr_dirty), .wr_line_o(arr_wr_line),
        .wr_byte_en_o(arr_wr_byte_en),
        .push_o(push), .push_line_o(push_line), .push_addr_o(push_addr),
        .push_data_o(push_data), .push_strb_o(push_strb), .empty_i(wb_empty),
        .rd_req_o, .rd_type_o, .rd_addr_o, .rd_rdy_i, .ret_valid_i, .ret_data_i
    );

    dcache_ways ways_i (
        .clk, .rst,
        .rd_en_i(rd_en), .rd_index_i(rd_index), .cmp_tag_i(cmp_tag),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag), .victim_line_o(victim_line),
        .wr_en_i(arr_wr_en), .wr_way_i(arr_wr_way), .wr_index_i(arr_wr_index),
        .wr_tag_i(arr_wr_tag), .wr_dirty_i(arr_wr_dirty), .wr_line_i(arr_wr_line),
        .wr_byte_en_i(arr_wr_byte_en)
    );

    dcache_wb_buffer wb_i (
        .clk, .rst,
        .push_i(push), .push_line_i(push_line), .push_addr_i(push_addr),
        .push_data_i(push_data), .push_strb_i(push_strb), .empty_o(wb_empty),
        .wr_req_o, .wr_type_o, .wr_addr_o, .wr_wstrb_o, .wr_data_o, .wr_rdy_i
    );

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                valid_i,
    input  wire                                op_i,
    input  wire                                uncache_i,
    input  wire  [31:0]                        addr_i,
    input  wire  [3:0]                         wstrb_i,
    input  wire  [dcache_pkg::WORD_W-1:0]      wdata_i,
    output logic                               ready_o,
    output logic                               data_ok_o,
    output logic [dcache_pkg::WORD_W-1:0]      rdata_o,
    output logic                               rd_en_o,
    output logic [dcache_pkg::INDEX_W-1:0]     rd_index_o,
    output logic [dcache_pkg::TAG_W-1:0]       cmp_tag_o,
    input  wire                                hit_i,
    input  wire                                hit_way_i,
    input  wire  dcache_pkg::line_t            hit_line_i,
    input  wire                                victim_way_i,
    input  wire                                victim_dirty_i,
    input  wire  [dcache_pkg::TAG_W-1:0]       victim_tag_i,
    input  wire  dcache_pkg::line_t            victim_line_i,
    output logic                               wr_en_o,
    output logic                               wr_way_o,
    output logic [dcache_pkg::INDEX_W-1:0]     wr_index_o,
    output logic [dcache_pkg::TAG_W-1:0]       wr_tag_o,
    output logic                               wr_dirty_o,
    output dcache_pkg::line_t                  wr_line_o,
    output logic [dcache_pkg::LINE_BYTES-1:0]  wr_byte_en_o,
    output logic                               push_o,
    output logic                               push_line_o,
    output logic [31:0]                        push_addr_o,
    output dcache_pkg::line_t                  push_data_o,
    output logic [dcache_pkg::LINE_BYTES-1:0]  push_strb_o,
    input  wire                                empty_i,
    output logic                               rd_req_o,
    output logic [2:0]                         rd_type_o,
    output logic [31:0]                        rd_addr_o,
    input  wire                                rd_rdy_i,
    input  wire                                ret_valid_i,
    input  wire  dcache_pkg::line_t            ret_data_i
);

    typedef enum logic [3:0] {
        S_IDLE, S_LOOKUP, S_MISS_WAIT, S_RD_REQ, S_RD_WAIT, S_REFILL,
        S_UNC_RD_REQ, S_UNC_RD_WAIT, S_UNC_WR
    } state_t;

    state_t                            state_q;
    state_t                            state_d;
    logic                              op_q;
    logic                              unc_q;
    logic [31:0]                       addr_q;
    logic [3:0]                        wstrb_q;
    logic [dcache_pkg::WORD_W-1:0]     wdata_q;
    dcache_pkg::line_t                 fill_q;
    dcache_pkg::line_t                 st_line;
    dcache_pkg::line_t                 merged;
    logic [dcache_pkg::LINE_BYTES-1:0] st_en;
    logic [1:0]                        lane;
    logic                              accept;

    assign ready_o = (state_q == S_IDLE);
    assign accept  = valid_i && ready_o;
    assign lane    = addr_q[3:2];

    always_ff @(posedge clk) begin
        if (rst) state_q <= S_IDLE;
        else state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op_i;
            unc_q   <= uncache_i;
            addr_q  <= addr_i;
            wstrb_q <= wstrb_i;
            wdata_q <= wdata_i;
        end
        if (state_q == S_RD_WAIT && ret_valid_i) fill_q <= ret_data_i;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) state_d = !uncache_i ? S_LOOKUP : (op_i ? S_UNC_WR : S_UNC_RD_REQ);
            end
            S_LOOKUP:      state_d = hit_i ? S_IDLE : S_MISS_WAIT;
            S_MISS_WAIT:   if (empty_i) state_d = S_RD_REQ;
            S_RD_REQ:      if (rd_rdy_i) state_d = S_RD_WAIT;
            S_RD_WAIT:     if (ret_valid_i) state_d = S_REFILL;
            S_REFILL:      state_d = S_IDLE;
            S_UNC_RD_REQ:  if (rd_req_o && rd_rdy_i) state_d = S_UNC_RD_WAIT;
            S_UNC_RD_WAIT: if (ret_valid_i) state_d = S_IDLE;
            S_UNC_WR:      if (empty_i) state_d = S_IDLE;
            default:       state_d = S_IDLE;
        endcase
    end

    // store word in every lane, strobes pick the target lane
    assign st_line = {4{wdata_q}};
    assign st_en   = {12'b0, wstrb_q} << {lane, 2'b00};

    always_comb begin
        for (int i = 0; i < dcache_pkg::LINE_BYTES; i++) begin
            merged.b[i] = (op_q && st_en[i]) ? st_line.b[i] : fill_q.b[i];
        end
    end

    assign rd_en_o    = accept;
    assign rd_index_o = addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign cmp_tag_o  = addr_q[31 -: dcache_pkg::TAG_W];
    assign wr_index_o = addr_q[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign wr_tag_o   = addr_q[31 -: dcache_pkg::TAG_W];

    always_comb begin
        wr_en_o      = 1'b0;
        wr_way_o     = victim_way_i;
        wr_dirty_o   = op_q; // store miss leaves the new line dirty
        wr_line_o    = merged;
        wr_byte_en_o = '1;
        if (state_q == S_LOOKUP) begin
            wr_en_o      = hit_i && op_q;
            wr_way_o     = hit_way_i;
            wr_dirty_o   = 1'b1;
            wr_line_o    = st_line;
            wr_byte_en_o = st_en;
        end else if (state_q == S_REFILL) begin
            wr_en_o = 1'b1;
        end
    end

    always_comb begin
        push_o      = 1'b0;
        push_line_o = 1'b0;
        push_addr_o = {addr_q[31:2], 2'b00};
        push_data_o = {{(dcache_pkg::LINE_W - dcache_pkg::WORD_W){1'b0}}, wdata_q}
                      << {lane, 5'b0};
        push_strb_o = st_en;
        if (state_q == S_MISS_WAIT) begin
            push_o      = empty_i && victim_dirty_i;
            push_line_o = 1'b1;
            push_addr_o = {victim_tag_i, wr_index_o, 4'b0};
            push_data_o = victim_line_i;
            push_strb_o = '1;
        end else if (state_q == S_UNC_WR) begin
            push_o = empty_i;
        end
    end

    // uncached read waits for the buffer so memory sees writes first
    assign rd_req_o  = (state_q == S_RD_REQ) || (state_q == S_UNC_RD_REQ && empty_i);
    assign rd_type_o = unc_q ? dcache_pkg::TYPE_WORD : dcache_pkg::TYPE_LINE;
    assign rd_addr_o = unc_q ? {addr_q[31:2], 2'b00} : {addr_q[31:4], 4'b0};

    always_comb begin
        data_ok_o = 1'b0;
        rdata_o   = '0;
        case (state_q)
            S_LOOKUP: begin
                data_ok_o = hit_i;
                if (hit_i && !op_q) rdata_o = hit_line_i.w[lane];
            end
            S_REFILL: begin
                data_ok_o = 1'b1;
                if (!op_q) rdata_o = fill_q.w[lane];
            end
            S_UNC_RD_WAIT: begin
                data_ok_o = ret_valid_i;
                if (ret_valid_i) rdata_o = ret_data_i.w[lane];
            end
            S_UNC_WR: data_ok_o = empty_i;
            default: ;
        endcase
    end

    // every response closes a request and frees the port next cycle
    a_ok_then_ready: assert property (@(posedge clk) disable iff (rst)
        data_ok_o |-> !ready_o ##1 ready_o);

endmodule

`default_nettype wire

//--- rtl/dcache_wb_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_wb_buffer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                push_i,
    input  wire                                push_line_i,
    input  wire  [31:0]                        push_addr_i,
    input  wire  dcache_pkg::line_t            push_data_i,
    input  wire  [dcache_pkg::LINE_BYTES-1:0]  push_strb_i,
    output logic                               empty_o,
    output logic                               wr_req_o,
    output logic [2:0]                         wr_type_o,
    output logic [31:0]                        wr_addr_o,
    output logic [dcache_pkg::LINE_BYTES-1:0]  wr_wstrb_o,
    output logic [dcache_pkg::LINE_W-1:0]      wr_data_o,
    input  wire                                wr_rdy_i
);

    logic                              full_q;
    logic                              line_q; // victim line, else single word
    logic [31:0]                       addr_q;
    dcache_pkg::line_t                 data_q;
    logic [dcache_pkg::LINE_BYTES-1:0] strb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (push_i) begin
            full_q <= 1'b1;
        end else if (wr_rdy_i) begin
            full_q <= 1'b0; // retired by memory
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            line_q <= push_line_i;
            addr_q <= push_addr_i;
            data_q <= push_data_i;
            strb_q <= push_strb_i;
        end
    end

    assign empty_o    = !full_q;
    assign wr_req_o   = full_q;
    assign wr_type_o  = line_q ? dcache_pkg::TYPE_LINE : dcache_pkg::TYPE_WORD;
    assign wr_addr_o  = addr_q;
    assign wr_wstrb_o = strb_q;
    assign wr_data_o  = data_q;

    // controller must wait for empty_o
    a_no_overrun: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_q);

endmodule

`default_nettype wire

//--- rtl/dcache_ways.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ways (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  rd_en_i,
    input  wire  [dcache_pkg::INDEX_W-1:0]       rd_index_i,
    input  wire  [dcache_pkg::TAG_W-1:0]         cmp_tag_i,
    output logic                                 hit_o,
    output logic                                 hit_way_o,
    output dcache_pkg::line_t                    hit_line_o,
    output logic                                 victim_way_o,
    output logic                                 victim_dirty_o,
    output logic [dcache_pkg::TAG_W-1:0]         victim_tag_o,
    output dcache_pkg::line_t                    victim_line_o,
    input  wire                                  wr_en_i,
    input  wire                                  wr_way_i,
    input  wire  [dcache_pkg::INDEX_W-1:0]       wr_index_i,
    input  wire  [dcache_pkg::TAG_W-1:0]         wr_tag_i,
    input  wire                                  wr_dirty_i,
    input  wire  dcache_pkg::line_t              wr_line_i,
    input  wire  [dcache_pkg::LINE_BYTES-1:0]    wr_byte_en_i
);

    logic [dcache_pkg::NSET-1:0]   valid_q [dcache_pkg::NWAY];
    logic [dcache_pkg::NSET-1:0]   dirty_q [dcache_pkg::NWAY];
    logic [dcache_pkg::TAG_W-1:0]  tag_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    dcache_pkg::line_t             data_mem [dcache_pkg::NWAY][dcache_pkg::NSET];

    logic [dcache_pkg::NWAY-1:0]   vld_r;
    logic [dcache_pkg::NWAY-1:0]   dty_r;
    logic [dcache_pkg::TAG_W-1:0]  tag_r [dcache_pkg::NWAY];
    dcache_pkg::line_t             line_r [dcache_pkg::NWAY];
    logic [dcache_pkg::NWAY-1:0]   way_hit;
    logic [dcache_pkg::LFSR_W-1:0] lfsr_q;
    logic                          rand_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                valid_q[w] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_way_i][wr_index_i] <= 1'b1;
        end
    end

    // tag, dirty and byte-writable data
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            dirty_q[wr_way_i][wr_index_i] <= wr_dirty_i;
            tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
            for (int i = 0; i < dcache_pkg::LINE_BYTES; i++) begin
                if (wr_byte_en_i[i]) begin
                    data_mem[wr_way_i][wr_index_i].b[i] <= wr_line_i.b[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                vld_r[w]  <= valid_q[w][rd_index_i];
                dty_r[w]  <= dirty_q[w][rd_index_i];
                tag_r[w]  <= tag_mem[w][rd_index_i];
                line_r[w] <= data_mem[w][rd_index_i];
            end
            rand_r <= lfsr_q[0]; // victim pick frozen with the set
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= dcache_pkg::LFSR_W'(1);
        end else begin
            lfsr_q <= {1'b0, lfsr_q[dcache_pkg::LFSR_W-1:1]}
                      ^ (lfsr_q[0] ? dcache_pkg::LFSR_TAPS : '0);
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            way_hit[w] = vld_r[w] && (tag_r[w] == cmp_tag_i);
        end
    end

    assign hit_o      = |way_hit;
    assign hit_way_o  = way_hit[1];
    assign hit_line_o = line_r[hit_way_o];

    // empty way first, random otherwise
    always_comb begin
        if (!vld_r[0]) begin
            victim_way_o = 1'b0;
        end else if (!vld_r[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = rand_r;
        end
    end

    assign victim_dirty_o = vld_r[victim_way_o] && dty_r[victim_way_o];
    assign victim_tag_o   = tag_r[victim_way_o];
    assign victim_line_o  = line_r[victim_way_o];

    // a refill never lands a tag already present in the other way
    a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int NWAY       = 2;
    localparam int NSET       = 256;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 8;
    localparam int TAG_W      = 20;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = 128;
    localparam int WORD_W     = 32;

    // replacement lfsr, galois form
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hb400; // x^16 + x^14 + x^13 + x^11 + 1

    // memory request types
    localparam logic [2:0] TYPE_WORD = 3'd2;
    localparam logic [2:0] TYPE_LINE = 3'd4;

    // one cache line, seen as words or as bytes
    typedef union packed {
        logic [LINE_BYTES/4-1:0][WORD_W-1:0] w;
        logic [LINE_BYTES-1:0][7:0]          b;
    } line_t;

endpackage

`default_nettype wire
